// ==== sprite.mem ====
// one 12-bit rgb word per line, row-major, 8 words per row; f00 is transparent.
F00
F00
502
503
504
505
F00
F00
F00
511
512
513
514
515
516
F00
520
521
F00
523
524
525
526
527
530
531
532
533
534
535
536
537
540
541
542
543
544
545
546
547
550
551
552
553
554
555
556
557
F00
561
562
563
564
565
566
F00
F00
F00
572
573
574
575
F00
F00

// ==== filelist.f ====
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/bg_draw.sv
verilog/sprite_regs.sv
verilog/sprite_draw.sv
verilog/vga_top.sv
dv/vga_top_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = vga_top_tb
FILELIST = filelist.f
PASS_MSG = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf obj_dir

// ==== dv/vga_top_tb.sv ====
`timescale 1ns/1ps

module vga_top_tb import vga_pkg::*; ();

    localparam int TIMEOUT = 2 * HOR_TOTAL * VER_TOTAL; // two frames.

    logic        clk;
    logic        rst;
    logic        cfg_valid;
    logic        cfg_ready;
    sprite_cfg_t cfg_data;
    vga_sig_t    vga_out;
    logic [11:0] model [0:SPR_SIZE*SPR_SIZE-1];
    sprite_cfg_t spr;
    sprite_cfg_t spr_b;
    int          seed   = 10540;
    int          checks = 0;
    int          errors = 0;
    int          tests  = 0;

    vga_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_data  (cfg_data),
        .vga_out   (vga_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_rgb(input string name, input logic [11:0] got, input logic [11:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cfg(input string name, input sprite_cfg_t got, input sprite_cfg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // screen colour with no sprite.
    function automatic logic [11:0] bg_color(input int h, input int v);
        if (h >= HOR_PIXELS || v >= VER_PIXELS) return 12'h000;
        if (h == 0 || v == 0 || h == HOR_PIXELS - 1 || v == VER_PIXELS - 1) return BORDER_COLOR;
        return BG_COLOR;
    endfunction

    // one mid-cycle sample with blanking checks.
    task automatic tick(input string what, inout int n);
        @(negedge clk);
        n++;
        if (n > TIMEOUT) begin
            $display("timeout while waiting for %s", what);
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            $display("*** FAILED ***");
            $finish;
        end else begin
            verify_flag("hblnk", vga_out.hblnk, int'(vga_out.hcount) >= HOR_PIXELS);
            verify_flag("vblnk", vga_out.vblnk, int'(vga_out.vcount) >= VER_PIXELS);
            if (int'(vga_out.hcount) >= HOR_PIXELS) begin
                check_rgb("rgb in blanking", vga_out.rgb, 12'h000);
            end
        end
    endtask

    task automatic wait_pos(input int h, input int v);
        int n;
        n = 0;
        do tick("raster position", n);
        while (int'(vga_out.hcount) != h || int'(vga_out.vcount) != v);
    endtask

    task automatic wait_commit();
        int n;
        n = 0;
        do tick("vblank commit", n);
        while (!cfg_ready);
    endtask

    task automatic write_cfg(input sprite_cfg_t cfg);
        int n;
        @(posedge clk);
        #1;
        cfg_valid = 1'b1;
        cfg_data  = cfg;
        n = 0;
        do tick("cfg_ready", n);
        while (!cfg_ready);
        @(posedge clk); // transfer edge.
        #1;
        cfg_valid = 1'b0;
    endtask

    // window plus one column either side over the 32 window lines.
    task automatic scan_window(input sprite_cfg_t cfg);
        int          x0;
        int          y0;
        int          h;
        int          v;
        int          c;
        logic [11:0] pix;
        logic [11:0] exp;
        x0 = int'(cfg.pos_x) - SPR_HALF;
        y0 = int'(cfg.pos_y) - SPR_HALF;
        wait_pos(0, y0);
        repeat (2 * SPR_HALF * HOR_TOTAL) begin
            h = int'(vga_out.hcount);
            v = int'(vga_out.vcount);
            if (h >= x0 - 1 && h <= x0 + 2 * SPR_HALF) begin
                exp = bg_color(h, v);
                if (cfg.enable && h >= x0 && h < x0 + 2 * SPR_HALF) begin
                    c = (h - x0) / SPR_SCALE;
                    if (cfg.flip_h) c = SPR_SIZE - 1 - c;
                    pix = model[6'(((v - y0) / SPR_SCALE) * SPR_SIZE + c)];
                    if (pix != KEY_COLOR) exp = pix;
                end
                check_rgb($sformatf("rgb at %0d,%0d", h, v), vga_out.rgb, exp);
            end
            @(negedge clk);
        end
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        $display("test %-12s finished with %0d errors", name, errors - e0);
    endtask

    task automatic reset_state();
        int          e0;
        int          n;
        sprite_cfg_t exp_cfg;
        e0 = errors;
        exp_cfg = '{pos_x: 12'd400, pos_y: 12'd300, flip_h: 1'b0, enable: 1'b0, spare: 1'b0};
        repeat (4) @(posedge clk);
        @(negedge clk);
        verify_flag("hsync", vga_out.hsync, 1'b0);
        verify_flag("vsync", vga_out.vsync, 1'b0);
        check_rgb("rgb", vga_out.rgb, 12'h000);
        verify_flag("cfg_ready", cfg_ready, 1'b1);
        @(posedge clk);
        #1;
        rst = 1'b0; // 5 cycles of reset.
        @(negedge clk);
        verify_flag("hsync", vga_out.hsync, 1'b0);
        verify_flag("vsync", vga_out.vsync, 1'b0);
        check_rgb("rgb", vga_out.rgb, 12'h000);
        verify_flag("cfg_ready", cfg_ready, 1'b1);
        check_cfg("active_cfg", u_dut.active_cfg, exp_cfg);
        n = 0;
        do tick("first count", n);
        while (vga_out.hcount == '0);
        // first count leaves the timing stage one cycle after reset.
        compare_count("pipeline latency", n, 1 + BG_LAT + SPR_LAT);
        wait_pos(HOR_PIXELS / 2, VER_PIXELS / 2);
        check_rgb("rgb at centre", vga_out.rgb, bg_color(HOR_PIXELS / 2, VER_PIXELS / 2));
        report("reset", e0);
    endtask

    task automatic raster_timing();
        int e0;
        int n;
        int high;
        e0 = errors;
        n = 0;
        do tick("hsync low", n);
        while (vga_out.hsync);
        n = 0;
        do tick("hsync rise", n);
        while (!vga_out.hsync);
        high = 0;
        do tick("hsync fall", high);
        while (vga_out.hsync);
        compare_count("hsync width", high, 128);
        n = high;
        do tick("hsync rise", n); // n keeps counting over the whole line.
        while (!vga_out.hsync);
        compare_count("hsync period", n, HOR_TOTAL);
        n = 0;
        do tick("vsync low", n);
        while (vga_out.vsync);
        n = 0;
        do tick("vsync rise", n);
        while (!vga_out.vsync);
        high = 0;
        do tick("vsync fall", high);
        while (vga_out.vsync);
        compare_count("vsync width", high, 4 * HOR_TOTAL);
        report("timing", e0);
    endtask

    task automatic background_fill();
        int e0;
        e0 = errors;
        wait_pos(HOR_PIXELS / 2, 0);
        check_rgb("rgb on row 0", vga_out.rgb, BORDER_COLOR);
        wait_pos(HOR_PIXELS - 1, 200);
        check_rgb("rgb on column 799", vga_out.rgb, BORDER_COLOR);
        wait_pos(HOR_PIXELS / 4, 201);
        check_rgb("rgb in interior", vga_out.rgb, BG_COLOR);
        report("background", e0);
    endtask

    task automatic sprite_overlay(input logic flip, input string name);
        int e0;
        e0 = errors;
        spr.flip_h = flip;
        write_cfg(spr);
        wait_commit();
        check_cfg("active_cfg", u_dut.active_cfg, spr);
        scan_window(spr);
        report(name, e0);
    endtask

    task automatic frame_commit();
        int          e0;
        sprite_cfg_t first;
        e0 = errors;
        first = spr;
        first.flip_h = 1'b0;
        wait_pos(0, 0);
        write_cfg(first);
        cfg_valid = 1'b1; // second write is held until the slot frees.
        cfg_data  = spr_b;
        @(negedge clk);
        verify_flag("cfg_ready", cfg_ready, 1'b0);
        scan_window(spr);
        verify_flag("cfg_ready", cfg_ready, 1'b0);
        write_cfg(spr_b);
        check_cfg("active_cfg", u_dut.active_cfg, first);
        scan_window(first);
        wait_commit();
        check_cfg("active_cfg", u_dut.active_cfg, spr_b);
        scan_window(spr_b);
        report("commit", e0);
    endtask

    initial begin
        rst       = 1'b1;
        cfg_valid = 1'b0;
        cfg_data  = '0;
        $readmemh(SPR_FILE, model);
        spr          = '0;
        spr.pos_x    = 12'(20 + $unsigned($random(seed)) % 760);
        spr.pos_y    = 12'(20 + $unsigned($random(seed)) % 560);
        spr.enable   = 1'b1;
        spr_b        = spr;
        spr_b.pos_x  = 12'(20 + $unsigned($random(seed)) % 760);
        spr_b.pos_y  = 12'(20 + $unsigned($random(seed)) % 560);
        spr_b.flip_h = 1'b1;
        reset_state();
        raster_timing();
        background_fill();
        sprite_overlay(1'b0, "sprite");
        sprite_overlay(1'b1, "flip");
        frame_commit();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/vga_top.sv ====
`timescale 1ns/1ps

module vga_top import vga_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_valid,
    output logic        cfg_ready,
    input  sprite_cfg_t cfg_data,
    output vga_sig_t    vga_out
);

    vga_sig_t    vga_tim;
    vga_sig_t    vga_bg;
    sprite_cfg_t active_cfg;
    logic        frame_start;

    vga_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .vga         (vga_tim),
        .frame_start (frame_start)
    );

    bg_draw u_bg (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_tim),
        .vga_out (vga_bg)
    );

    sprite_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_data    (cfg_data),
        .frame_start (frame_start),
        .active_cfg  (active_cfg)
    );

    sprite_draw u_sprite (
        .clk     (clk),
        .rst     (rst),
        .cfg     (active_cfg),
        .vga_in  (vga_bg),
        .vga_out (vga_out)  // timing delayed by 4.
    );

endmodule

// ==== verilog/sprite_draw.sv ====
`timescale 1ns/1ps

module sprite_draw import vga_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  sprite_cfg_t cfg,
    input  vga_sig_t    vga_in,
    output vga_sig_t    vga_out
);

    logic [11:0] rom [0:SPR_SIZE*SPR_SIZE-1];

    initial $readmemh(SPR_FILE, rom);

    logic [12:0] rel_x;
    logic [12:0] rel_y;
    logic        in_win;
    logic [2:0]  col_raw;
    logic [2:0]  col;
    logic [2:0]  row;
    logic [5:0]  addr;

    vga_sig_t    vga_s1;
    logic        in_win_s1;
    logic [5:0]  addr_s1;

    vga_sig_t    vga_s2;
    logic        in_win_s2;
    logic [11:0] rom_rgb_s2;

    // stage 1 works on the incoming pixel and the current config
    always_comb begin
        // negative offsets from the window corner wrap to large values.
        rel_x   = 13'(vga_in.hcount) - 13'(cfg.pos_x) + 13'(SPR_HALF);
        rel_y   = 13'(vga_in.vcount) - 13'(cfg.pos_y) + 13'(SPR_HALF);
        in_win  = cfg.enable && !vga_in.hblnk && !vga_in.vblnk
               && (rel_x < 13'(2 * SPR_HALF)) && (rel_y < 13'(2 * SPR_HALF));
        col_raw = 3'(rel_x / SPR_SCALE);
        row     = 3'(rel_y / SPR_SCALE);
        if (cfg.flip_h) begin
            col = 3'(SPR_SIZE - 1) - col_raw;
        end else begin
            col = col_raw;
        end
        addr    = 6'(row * SPR_SIZE + col);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_s1    <= '0;
            in_win_s1 <= 1'b0;
        end else begin
            vga_s1    <= vga_in;
            in_win_s1 <= in_win;
        end
    end

    always_ff @(posedge clk) begin
        addr_s1 <= addr;
    end

    // stage 2 reads the rom.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_s2    <= '0;
            in_win_s2 <= 1'b0;
        end else begin
            vga_s2    <= vga_s1;
            in_win_s2 <= in_win_s1;
        end
    end

    always_ff @(posedge clk) begin
        rom_rgb_s2 <= rom[addr_s1];
    end

    // stage 3 applies the colour key.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_s2;
            if (in_win_s2 && (rom_rgb_s2 != KEY_COLOR)) begin
                vga_out.rgb <= rom_rgb_s2;
            end
        end
    end

endmodule

// ==== verilog/sprite_regs.sv ====
`timescale 1ns/1ps

module sprite_regs import vga_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_valid,
    output logic        cfg_ready,
    input  sprite_cfg_t cfg_data,
    input  logic        frame_start,
    output sprite_cfg_t active_cfg
);

    regs_state_t state;
    sprite_cfg_t pending;

    // one slot only, so a second writer waits for the next vblank.
    assign cfg_ready = (state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            active_cfg.pos_x  <= 12'(HOR_PIXELS / 2);
            active_cfg.pos_y  <= 12'(VER_PIXELS / 2);
            active_cfg.flip_h <= 1'b0;
            active_cfg.enable <= 1'b0;
            active_cfg.spare  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg_valid) begin
                        state <= PENDING;
                    end
                end
                PENDING: begin
                    if (frame_start) begin
                        active_cfg <= pending; // commit at start of vblank.
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_valid && cfg_ready) begin
            pending       <= cfg_data;
            pending.spare <= 1'b0;
        end
    end

    a_accept_blocks: assert property (
        @(posedge clk) disable iff (rst)
        (cfg_valid && cfg_ready) |=> (state == PENDING) && !cfg_ready
    ) else $error("cfg_ready high after accepted write.");

    a_commit_at_vblank: assert property (
        @(posedge clk) disable iff (rst)
        (active_cfg != $past(active_cfg)) |-> $past(frame_start)
    ) else $error("active config changed outside vblank commit.");

endmodule

// ==== verilog/bg_draw.sv ====
`timescale 1ns/1ps

module bg_draw import vga_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  vga_sig_t vga_in,
    output vga_sig_t vga_out
);

    logic        border;
    logic [11:0] rgb_nxt;

    always_comb begin
        border = (vga_in.vcount == '0) || (vga_in.vcount == 11'(VER_PIXELS - 1))
              || (vga_in.hcount == '0) || (vga_in.hcount == 11'(HOR_PIXELS - 1));
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;               // black in blanking.
        end else if (border) begin
            rgb_nxt = BORDER_COLOR;
        end else begin
            rgb_nxt = BG_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing import vga_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output vga_sig_t vga,
    output logic     frame_start
);

    logic [10:0] h_nxt;
    logic [10:0] v_nxt;

    // counters advance one pixel per clock and wrap at the totals
    always_comb begin
        h_nxt = vga.hcount + 11'd1;
        v_nxt = vga.vcount;
        if (vga.hcount == 11'(HOR_TOTAL - 1)) begin
            h_nxt = '0;
            if (vga.vcount == 11'(VER_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vga.vcount + 11'd1;
            end
        end
    end

    // everything is decoded from the next count, so outputs stay aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga         <= '0;
            frame_start <= 1'b0;
        end else begin
            vga.hcount  <= h_nxt;
            vga.vcount  <= v_nxt;
            vga.hsync   <= (h_nxt >= 11'(HOR_SYNC_START)) && (h_nxt < 11'(HOR_SYNC_END));
            vga.vsync   <= (v_nxt >= 11'(VER_SYNC_START)) && (v_nxt < 11'(VER_SYNC_END));
            vga.hblnk   <= h_nxt >= 11'(HOR_PIXELS);
            vga.vblnk   <= v_nxt >= 11'(VER_PIXELS);
            vga.rgb     <= '0;
            frame_start <= (h_nxt == '0) && (v_nxt == 11'(VER_PIXELS)); // first vblank line.
        end
    end

    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst)
        vga.hcount < 11'(HOR_TOTAL)
    ) else $error("hcount reached HOR_TOTAL.");

endmodule

// ==== verilog/vga_pkg.sv ====
package vga_pkg;

    // SVGA 800x600 at 60 Hz, 40 MHz pixel clock.
    localparam int HOR_PIXELS     = 800;
    localparam int HOR_TOTAL      = 1056;
    localparam int HOR_SYNC_START = 840;
    localparam int HOR_SYNC_END   = 968;

    localparam int VER_PIXELS     = 600;
    localparam int VER_TOTAL      = 628;
    localparam int VER_SYNC_START = 601;
    localparam int VER_SYNC_END   = 605;

    localparam logic [11:0] BG_COLOR     = 12'h124;
    localparam logic [11:0] BORDER_COLOR = 12'hFFF;
    localparam logic [11:0] KEY_COLOR    = 12'hF00; // transparent.

    localparam int SPR_SIZE  = 8;  // rom side in pixels.
    localparam int SPR_SCALE = 4;
    localparam int SPR_HALF  = 16; // half extent on screen.
    localparam     SPR_FILE  = "sprite.mem";

    localparam int BG_LAT  = 1;
    localparam int SPR_LAT = 3;

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_sig_t;

    typedef struct packed {
        logic [11:0] pos_x;  // sprite centre.
        logic [11:0] pos_y;  // sprite centre.
        logic        flip_h;
        logic        enable;
        logic        spare;
    } sprite_cfg_t;

    typedef enum logic {IDLE, PENDING} regs_state_t;

endpackage
